/* dcache_pkg.sv */
// cache geometry constants
// request, response and bus channel types
// stage-2 control word shared by the top level and the miss FSM
`default_nettype none

package dcache_pkg;

  // 2-way, 16 sets, 16-byte lines
  localparam int WAY_NUM    = 2;
  localparam int WAY_WIDTH  = 1;
  localparam int IDX_WIDTH  = 4;
  localparam int SET_NUM    = 1 << IDX_WIDTH;
  localparam int LINE_BYTES = 16;
  localparam int LINE_WORDS = LINE_BYTES / 4;
  localparam int ADDR_WIDTH = 32;
  localparam int OFS_WIDTH  = 4;
  localparam int TAG_WIDTH  = ADDR_WIDTH - IDX_WIDTH - OFS_WIDTH;

  typedef enum logic {
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

  // size and sign of an access
  typedef enum logic [2:0] {
    ALIGN_B,
    ALIGN_H,
    ALIGN_W,
    ALIGN_BU,
    ALIGN_HU
  } align_e;

  typedef logic [TAG_WIDTH-1:0] tag_t;
  typedef logic [LINE_BYTES-1:0][7:0] line_t;

  typedef struct packed {
    logic valid;
    logic dirty;
  } meta_t;

  typedef struct packed {
    logic                  valid;
    mem_op_e               mem_op;
    align_e                align;
    logic [ADDR_WIDTH-1:0] vaddr;
    logic [31:0]           wdata;
  } dcache_req_t;

  typedef struct packed {
    logic        valid;
    logic        ale;
    logic [31:0] rdata;
  } dcache_rsp_t;

  // ==============================
  // bus channels
  // ==============================
  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
    logic [1:0]            len;
  } bus_ar_t;

  typedef bus_ar_t bus_aw_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic        last;
  } bus_r_t;

  typedef bus_r_t bus_w_t;

  typedef struct packed {
    logic ar_ready;
    logic aw_ready;
    logic w_ready;
  } bus_ready_t;

  // everything stage 2 knows about its item
  typedef struct packed {
    logic                  valid;
    logic                  miss;
    mem_op_e               mem_op;
    align_e                align;
    logic [ADDR_WIDTH-1:0] vaddr;
    logic [31:0]           wdata;
    logic [WAY_WIDTH-1:0]  hit_way;
    logic [WAY_WIDTH-1:0]  repl_way;
    tag_t                  repl_tag;
    logic                  repl_dirty;
    logic                  ale;
  } s2_ctrl_t;

endpackage

`default_nettype wire

/* dcache_ram.sv */
// simple dual-port memory, registered read, write-first on collision
// word type is a parameter so one block serves data, tag, meta and PLRU
`timescale 1ns/1ps
`default_nettype none

module dcache_ram import dcache_pkg::*; #(
  parameter type word_t = line_t,
  parameter int  DEPTH  = SET_NUM
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  word_t                    wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output word_t                    rdata_o
);

  // contents start cleared, every line begins invalid
  word_t mem [DEPTH] = '{default: '0};

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    // same-cycle write to the read address wins
    if (we_i && waddr_i == raddr_i) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

`default_nettype wire

/* dcache_lookup.sv */
// stage-1 tag compare and way selection
// PLRU victim choice and next PLRU bit
// same-cycle meta forwarding from stage 2
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup import dcache_pkg::*; (
  input  tag_t  [WAY_NUM-1:0] tag_row_i,
  input  meta_t [WAY_NUM-1:0] meta_row_i,
  input  logic                plru_i,
  input  tag_t                ptag_i,
  input  logic                fwd_we_i,
  input  logic                fwd_way_i,
  input  meta_t               fwd_meta_i,
  output logic                hit_o,
  output logic                hit_way_o,
  output logic                repl_way_o,
  output tag_t                repl_tag_o,
  output logic                repl_dirty_o,
  output logic                plru_next_o
);

  meta_t [WAY_NUM-1:0] meta;
  logic  [WAY_NUM-1:0] match;
  logic                used_way;

  // a store hit in stage 2 may be writing this very set right now
  always_comb begin
    meta = meta_row_i;
    if (fwd_we_i) begin
      meta[fwd_way_i] = fwd_meta_i;
    end
  end

  always_comb begin
    hit_way_o = 1'b0;
    for (int i = 0; i < WAY_NUM; i++) begin
      match[i] = meta[i].valid && tag_row_i[i] == ptag_i;
      if (match[i]) begin
        hit_way_o = 1'(i);
      end
    end
  end

  assign hit_o = |match;

  // victim comes straight from the PLRU bit
  assign repl_way_o   = plru_i;
  assign repl_tag_o   = tag_row_i[repl_way_o];
  assign repl_dirty_o = meta[repl_way_o].valid & meta[repl_way_o].dirty;

  // point the PLRU bit away from whichever way gets used
  assign used_way    = hit_o ? hit_way_o : repl_way_o;
  assign plru_next_o = ~used_way;

endmodule

`default_nettype wire

/* dcache_access.sv */
// stage-2 load extraction with sign or zero extension
// store byte merge into a copy of the line
`timescale 1ns/1ps
`default_nettype none

module dcache_access import dcache_pkg::*; (
  input  line_t                line_i,
  input  align_e               align_i,
  input  logic [OFS_WIDTH-1:0] vaddr_i,
  input  logic [31:0]          wdata_i,
  output logic [31:0]          rdata_o,
  output line_t                line_o
);

  logic [1:0]      wsel;
  logic [3:0][7:0] word;
  logic [7:0]      byte_v;
  logic [15:0]     half;
  logic [3:0][7:0] lane;
  logic [3:0]      be;

  assign wsel   = vaddr_i[3:2];
  assign word   = line_i[{wsel, 2'b00} +: 4];
  assign byte_v = word[vaddr_i[1:0]];
  assign half   = vaddr_i[1] ? {word[3], word[2]} : {word[1], word[0]};

  // load path
  always_comb begin
    case (align_i)
      ALIGN_B:  rdata_o = {{24{byte_v[7]}}, byte_v};
      ALIGN_BU: rdata_o = {24'h0, byte_v};
      ALIGN_H:  rdata_o = {{16{half[15]}}, half};
      ALIGN_HU: rdata_o = {16'h0, half};
      ALIGN_W:  rdata_o = word;
      default:  rdata_o = '0;
    endcase
  end

  // store path, data replicated across lanes and picked by byte enable
  always_comb begin
    case (align_i)
      ALIGN_B, ALIGN_BU: begin
        lane = {4{wdata_i[7:0]}};
        be   = 4'b0001 << vaddr_i[1:0];
      end
      ALIGN_H, ALIGN_HU: begin
        lane = {2{wdata_i[15:0]}};
        be   = 4'b0011 << {vaddr_i[1], 1'b0};
      end
      ALIGN_W: begin
        lane = wdata_i;
        be   = 4'b1111;
      end
      default: begin
        lane = wdata_i;
        be   = 4'b0000;
      end
    endcase
    line_o = line_i;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        line_o[{wsel, 2'(i)}] = lane[i];
      end
    end
  end

endmodule

`default_nettype wire

/* dcache_miss_fsm.sv */
// miss handling FSM
// dirty victim write-back burst, refill burst and refill buffer
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_fsm import dcache_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  s2_ctrl_t   s2_i,
  input  bus_r_t     bus_r_i,
  input  bus_ready_t bus_ready_i,
  input  line_t      dirty_line_i,
  output bus_ar_t    bus_ar_o,
  output bus_aw_t    bus_aw_o,
  output bus_w_t     bus_w_o,
  output logic       idle_o,
  output logic       refill_we_o,
  output line_t      refill_line_o
);

  typedef enum logic [2:0] {
    IDLE,
    WRITEBACK_ADDR,
    WRITEBACK,
    REFILL_ADDR,
    REFILL,
    RESUME
  } state_e;

  state_e                      state;
  state_e                      state_next;
  logic [1:0]                  beat;
  logic [LINE_WORDS-1:0][31:0] rbuf;
  logic [LINE_WORDS-1:0][31:0] line_words;
  logic [LINE_WORDS-1:0][31:0] victim_words;
  logic                        start;
  logic                        w_fire;
  logic                        r_fire;

  assign start  = s2_i.valid & s2_i.miss & ~s2_i.ale;
  assign w_fire = state == WRITEBACK && bus_ready_i.w_ready;
  // no r_ready, every beat is taken while refilling
  assign r_fire = state == REFILL && bus_r_i.valid;

  // ==============================
  // state transitions
  // ==============================
  always_comb begin
    state_next = state;
    case (state)
      IDLE:           if (start) state_next = s2_i.repl_dirty ? WRITEBACK_ADDR : REFILL_ADDR;
      WRITEBACK_ADDR: if (bus_ready_i.aw_ready) state_next = WRITEBACK;
      WRITEBACK:      if (w_fire && bus_w_o.last) state_next = REFILL_ADDR;
      REFILL_ADDR:    if (bus_ready_i.ar_ready) state_next = REFILL;
      REFILL:         if (r_fire && bus_r_i.last) state_next = RESUME;
      // one cycle for stage 2 to see the refilled line
      RESUME:         state_next = IDLE;
      default:        state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      beat  <= '0;
    end else begin
      state <= state_next;
      if (state == IDLE) begin
        beat <= '0;
      end else if (w_fire || r_fire) begin
        beat <= beat + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (r_fire) begin
      rbuf[beat] <= bus_r_i.data;
    end
  end

  // ==============================
  // outputs
  // ==============================
  assign victim_words = dirty_line_i;

  // last beat goes straight into the line, skipping the buffer
  always_comb begin
    line_words       = rbuf;
    line_words[beat] = bus_r_i.data;
  end

  assign refill_line_o = line_words;
  assign refill_we_o   = r_fire & bus_r_i.last;
  assign idle_o        = state == IDLE;

  always_comb begin
    bus_aw_o.valid = state == WRITEBACK_ADDR;
    bus_aw_o.addr  = {s2_i.repl_tag, s2_i.vaddr[OFS_WIDTH +: IDX_WIDTH], {OFS_WIDTH{1'b0}}};
    bus_aw_o.len   = 2'(LINE_WORDS - 1);

    bus_w_o.valid  = state == WRITEBACK;
    bus_w_o.data   = victim_words[beat];
    bus_w_o.last   = beat == 2'(LINE_WORDS - 1);

    bus_ar_o.valid = state == REFILL_ADDR;
    bus_ar_o.addr  = {s2_i.vaddr[ADDR_WIDTH-1:OFS_WIDTH], {OFS_WIDTH{1'b0}}};
    bus_ar_o.len   = 2'(LINE_WORDS - 1);
  end

endmodule

`default_nettype wire

/* dcache_top.sv */
// data cache top level
// stage registers, ready chain, memory arrays and their write control
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  dcache_req_t req_i,
  output logic        req_ready_o,
  output dcache_rsp_t rsp_o,
  output bus_ar_t     bus_ar_o,
  input  bus_r_t      bus_r_i,
  output bus_aw_t     bus_aw_o,
  output bus_w_t      bus_w_o,
  input  bus_ready_t  bus_ready_i
);

  logic                 s0_ale;
  logic                 s1_ready;
  logic                 s2_ready;
  logic                 s2_done;
  logic                 resume_q;
  dcache_req_t          s1_req;
  logic                 s1_ale;
  s2_ctrl_t             s2;
  logic [IDX_WIDTH-1:0] req_idx;
  logic [IDX_WIDTH-1:0] s1_idx;
  logic [IDX_WIDTH-1:0] s2_idx;
  logic [IDX_WIDTH-1:0] tm_raddr;
  logic [IDX_WIDTH-1:0] data_raddr;
  line_t [WAY_NUM-1:0]  data_rdata;
  tag_t  [WAY_NUM-1:0]  tag_rdata;
  meta_t [WAY_NUM-1:0]  meta_rdata;
  logic                 plru_rdata;
  logic                 plru_we;
  logic [WAY_NUM-1:0]   data_we;
  logic [WAY_NUM-1:0]   tag_we;
  meta_t                meta_wdata;
  line_t                line_wdata;
  logic                 s2_store;
  logic                 store_hit;
  logic                 s2_way;
  logic                 wr_way;
  line_t                acc_line;
  line_t                merged_line;
  logic [31:0]          load_data;
  logic                 hit;
  logic                 hit_way;
  logic                 repl_way;
  tag_t                 repl_tag;
  logic                 repl_dirty;
  logic                 plru_next;
  logic                 fsm_idle;
  logic                 refill_we;
  line_t                refill_line;

  assign req_idx = req_i.vaddr[OFS_WIDTH +: IDX_WIDTH];
  assign s1_idx  = s1_req.vaddr[OFS_WIDTH +: IDX_WIDTH];
  assign s2_idx  = s2.vaddr[OFS_WIDTH +: IDX_WIDTH];

  // ==============================
  // stage 0 and ready chain
  // ==============================
  always_comb begin
    case (req_i.align)
      ALIGN_H, ALIGN_HU: s0_ale = req_i.vaddr[0];
      ALIGN_W:           s0_ale = |req_i.vaddr[1:0];
      default:           s0_ale = 1'b0;
    endcase
  end

  // a miss retires in the RESUME cycle, right after its refill write
  assign s2_done     = s2.valid & (s2.ale | (~s2.miss & fsm_idle) | resume_q);
  assign s2_ready    = ~s2.valid | s2_done;
  assign s1_ready    = ~s1_req.valid | s2_ready;
  assign req_ready_o = s1_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_req <= '0;
      s1_ale <= 1'b0;
    end else if (s1_ready) begin
      s1_req <= req_i;
      s1_ale <= s0_ale;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2       <= '0;
      resume_q <= 1'b0;
    end else begin
      resume_q <= refill_we;
      if (s2_ready) begin
        s2.valid      <= s1_req.valid;
        s2.miss       <= ~hit;
        s2.mem_op     <= s1_req.mem_op;
        s2.align      <= s1_req.align;
        s2.vaddr      <= s1_req.vaddr;
        s2.wdata      <= s1_req.wdata;
        s2.hit_way    <= hit_way;
        s2.repl_way   <= repl_way;
        s2.repl_tag   <= repl_tag;
        s2.repl_dirty <= repl_dirty;
        s2.ale        <= s1_ale;
      end
    end
  end

  // ==============================
  // memory arrays
  // ==============================
  // tag/meta/plru read in stage 0, data read in stage 1
  assign tm_raddr   = s1_ready ? req_idx : s1_idx;
  assign data_raddr = s2_ready ? s1_idx : s2_idx;

  for (genvar i = 0; i < WAY_NUM; i++) begin : g_way
    dcache_ram #(.word_t(line_t), .DEPTH(SET_NUM)) u_data (
      .clk, .we_i(data_we[i]), .waddr_i(s2_idx), .wdata_i(line_wdata),
      .raddr_i(data_raddr), .rdata_o(data_rdata[i])
    );
    dcache_ram #(.word_t(tag_t), .DEPTH(SET_NUM)) u_tag (
      .clk, .we_i(tag_we[i]), .waddr_i(s2_idx), .wdata_i(s2.vaddr[ADDR_WIDTH-1 -: TAG_WIDTH]),
      .raddr_i(tm_raddr), .rdata_o(tag_rdata[i])
    );
    dcache_ram #(.word_t(meta_t), .DEPTH(SET_NUM)) u_meta (
      .clk, .we_i(data_we[i]), .waddr_i(s2_idx), .wdata_i(meta_wdata),
      .raddr_i(tm_raddr), .rdata_o(meta_rdata[i])
    );
  end

  // updated as each aligned item leaves stage 1
  assign plru_we = s1_req.valid & ~s1_ale & s2_ready;

  dcache_ram #(.word_t(logic), .DEPTH(SET_NUM)) u_plru (
    .clk, .we_i(plru_we), .waddr_i(s1_idx), .wdata_i(plru_next),
    .raddr_i(tm_raddr), .rdata_o(plru_rdata)
  );

  // store hit sets dirty, refill sets valid and dirty on a store
  assign s2_store   = s2.mem_op == MEM_STORE;
  assign store_hit  = s2.valid & ~s2.ale & ~s2.miss & s2_store & fsm_idle;
  assign s2_way     = s2.miss ? s2.repl_way : s2.hit_way;
  assign wr_way     = refill_we ? s2.repl_way : s2.hit_way;
  assign meta_wdata = '{valid: 1'b1, dirty: s2_store};
  assign acc_line   = refill_we ? refill_line : data_rdata[s2_way];
  assign line_wdata = s2_store ? merged_line : acc_line;

  always_comb begin
    for (int i = 0; i < WAY_NUM; i++) begin
      data_we[i] = (store_hit | refill_we) & (wr_way == WAY_WIDTH'(i));
      tag_we[i]  = refill_we & (s2.repl_way == WAY_WIDTH'(i));
    end
  end

  dcache_lookup u_lookup (
    .tag_row_i(tag_rdata), .meta_row_i(meta_rdata), .plru_i(plru_rdata),
    .ptag_i(s1_req.vaddr[ADDR_WIDTH-1 -: TAG_WIDTH]),
    .fwd_we_i((store_hit | refill_we) & (s1_idx == s2_idx)),
    .fwd_way_i(wr_way), .fwd_meta_i(meta_wdata),
    .hit_o(hit), .hit_way_o(hit_way), .repl_way_o(repl_way), .repl_tag_o(repl_tag),
    .repl_dirty_o(repl_dirty), .plru_next_o(plru_next)
  );

  dcache_access u_access (
    .line_i(acc_line), .align_i(s2.align), .vaddr_i(s2.vaddr[OFS_WIDTH-1:0]),
    .wdata_i(s2.wdata), .rdata_o(load_data), .line_o(merged_line)
  );

  dcache_miss_fsm u_miss_fsm (
    .clk, .rst_n, .s2_i(s2), .bus_r_i, .bus_ready_i,
    .dirty_line_i(data_rdata[s2.repl_way]),
    .bus_ar_o, .bus_aw_o, .bus_w_o,
    .idle_o(fsm_idle), .refill_we_o(refill_we), .refill_line_o(refill_line)
  );

  always_comb begin
    rsp_o.valid = s2_done;
    rsp_o.ale   = s2.ale;
    rsp_o.rdata = s2.ale ? '0 : load_data;
  end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// testbench clock and reset source
// 100 ns clock, reset low for the first 8 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    // half of the 100 ns period
    forever #50 clk_o = ~clk_o;
  end

  // released on a falling edge like every other DUT input
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* dcache_sva.sv */
// bound checks on the cache bus and response stream
// valid held until ready, responses only after acceptance, burst length
`timescale 1ns/1ps
`default_nettype none

module dcache_sva import dcache_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input dcache_req_t req_i,
  input logic        req_ready_i,
  input dcache_rsp_t rsp_i,
  input bus_ar_t     ar_i,
  input bus_aw_t     aw_i,
  input bus_w_t      w_i,
  input bus_ready_t  ready_i
);

  logic [3:0] in_flight;
  logic [1:0] w_beats;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= '0;
      w_beats   <= '0;
    end else begin
      in_flight <= in_flight + 4'(req_i.valid & req_ready_i) - 4'(rsp_i.valid);
      if (w_i.valid && ready_i.w_ready) begin
        w_beats <= w_beats + 2'd1;
      end
    end
  end

  // ==============================
  // bus handshakes
  // ==============================
  ar_held: assert property (@(posedge clk) disable iff (!rst_n)
    ar_i.valid && !ready_i.ar_ready |=> ar_i.valid)
    else $error("read address valid dropped before ready");

  aw_held: assert property (@(posedge clk) disable iff (!rst_n)
    aw_i.valid && !ready_i.aw_ready |=> aw_i.valid)
    else $error("write address valid dropped before ready");

  w_held: assert property (@(posedge clk) disable iff (!rst_n)
    w_i.valid && !ready_i.w_ready |=> w_i.valid)
    else $error("write data valid dropped before ready");

  // last only on the fourth beat
  w_last: assert property (@(posedge clk) disable iff (!rst_n)
    w_i.valid && ready_i.w_ready |-> w_i.last == (w_beats == 2'd3))
    else $error("write burst last flag on the wrong beat");

  rsp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_i.valid |-> in_flight != 4'd0)
    else $error("response with no accepted request");

endmodule

`default_nettype wire

/* dcache_tb.sv */
// testbench top for the data cache
// bus slave model with a 4 KB memory and random ready delays
// byte-memory reference model, directed and random stimulus, response checker
`timescale 1ns/1ps
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

  typedef struct packed {
    mem_op_e     op;
    align_e      align;
    logic [11:0] addr;
    logic [31:0] wdata;
    logic        chk_lat;
    logic [63:0] t_issue;
  } req_rec_t;

  logic        clk;
  logic        rst_n;
  dcache_req_t req;
  logic        req_ready;
  dcache_rsp_t rsp;
  bus_ar_t     bus_ar;
  bus_r_t      bus_r;
  bus_aw_t     bus_aw;
  bus_w_t      bus_w;
  bus_ready_t  bus_ready;

  logic [7:0]  slave_mem [4096];
  logic [7:0]  ref_mem [4096];
  req_rec_t    pending_q [$];
  int          reads = 0;
  int          writebacks = 0;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  dcache_top dut (
    .clk(clk), .rst_n(rst_n), .req_i(req), .req_ready_o(req_ready), .rsp_o(rsp),
    .bus_ar_o(bus_ar), .bus_r_i(bus_r), .bus_aw_o(bus_aw), .bus_w_o(bus_w),
    .bus_ready_i(bus_ready)
  );

  bind dcache_top dcache_sva u_sva (
    .clk(clk), .rst_n(rst_n), .req_i(req_i), .req_ready_i(req_ready_o), .rsp_i(rsp_o),
    .ar_i(bus_ar_o), .aw_i(bus_aw_o), .w_i(bus_w_o), .ready_i(bus_ready_i)
  );

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // every address bit feeds the initial byte
  function automatic logic [7:0] fill_byte(logic [11:0] a);
    return ({a[3:0], a[11:8]} ^ a[7:0]) + 8'h5c;
  endfunction

  function automatic logic is_misaligned(align_e al, logic [11:0] a);
    case (al)
      ALIGN_H, ALIGN_HU: return a[0];
      ALIGN_W:           return a[1:0] != 2'b00;
      default:           return 1'b0;
    endcase
  endfunction

  // ==============================
  // reference model
  // ==============================
  function automatic logic [31:0] expected_load(logic [11:0] a, align_e al);
    logic [7:0]  b;
    logic [15:0] h;
    b = ref_mem[a];
    h = {ref_mem[a + 12'd1], ref_mem[a]};
    case (al)
      ALIGN_B:  return {{24{b[7]}}, b};
      ALIGN_BU: return {24'h0, b};
      ALIGN_H:  return {{16{h[15]}}, h};
      ALIGN_HU: return {16'h0, h};
      default:  return {ref_mem[a + 12'd3], ref_mem[a + 12'd2], h};
    endcase
  endfunction

  task automatic apply_store(logic [11:0] a, align_e al, logic [31:0] wd);
    int n;
    case (al)
      ALIGN_B, ALIGN_BU: n = 1;
      ALIGN_H, ALIGN_HU: n = 2;
      default:           n = 4;
    endcase
    for (int k = 0; k < n; k++) begin
      ref_mem[a + 12'(k)] = wd[8*k +: 8];
    end
  endtask

  // ==============================
  // bus slave
  // ==============================
  task automatic serve_read();
    logic [11:0] base;
    logic [11:0] a;
    int          d;
    assert (bus_ar.len == 2'd3 && bus_ar.addr[3:0] == 4'h0 && bus_ar.addr[31:12] == '0)
    else begin
      $display("read burst with a bad address or length at %0t", $time);
      stop_with_failure();
    end
    base = bus_ar.addr[11:0];
    d = $urandom_range(0, 3);
    repeat (d) @(negedge clk);
    bus_ready.ar_ready = 1'b1;
    @(negedge clk);
    bus_ready.ar_ready = 1'b0;
    for (int b = 0; b < 4; b++) begin
      d = $urandom_range(0, 3);
      repeat (d) @(negedge clk);
      a = base + 12'(4 * b);
      bus_r.valid = 1'b1;
      bus_r.data  = {slave_mem[a + 12'd3], slave_mem[a + 12'd2],
                     slave_mem[a + 12'd1], slave_mem[a]};
      bus_r.last  = b == 3;
      @(negedge clk);
      bus_r = '0;
    end
    reads++;
  endtask

  task automatic serve_write();
    logic [11:0] base;
    logic [11:0] a;
    int          d;
    assert (bus_aw.len == 2'd3 && bus_aw.addr[3:0] == 4'h0 && bus_aw.addr[31:12] == '0)
    else begin
      $display("write burst with a bad address or length at %0t", $time);
      stop_with_failure();
    end
    base = bus_aw.addr[11:0];
    d = $urandom_range(0, 3);
    repeat (d) @(negedge clk);
    bus_ready.aw_ready = 1'b1;
    @(negedge clk);
    bus_ready.aw_ready = 1'b0;
    for (int b = 0; b < 4; b++) begin
      d = $urandom_range(0, 3);
      repeat (d) @(negedge clk);
      assert (bus_w.valid) else begin
        $display("write data beat missing after the address handshake at %0t", $time);
        stop_with_failure();
      end
      // last marks the fourth beat only
      assert (bus_w.last == (b == 3)) else begin
        $display("FAIL %0t: write beat %0d has last %0b", $time, b, bus_w.last);
        stop_with_failure();
      end
      a = base + 12'(4 * b);
      for (int k = 0; k < 4; k++) begin
        // a dirty line leaving the cache holds every retired store
        assert (bus_w.data[8*k +: 8] == ref_mem[a + 12'(k)]) else begin
          $display("FAIL %0t: write-back byte 0x%03h is %02h, expected %02h", $time,
                   a + 12'(k), bus_w.data[8*k +: 8], ref_mem[a + 12'(k)]);
          stop_with_failure();
        end
        slave_mem[a + 12'(k)] = bus_w.data[8*k +: 8];
      end
      bus_ready.w_ready = 1'b1;
      @(negedge clk);
      bus_ready.w_ready = 1'b0;
    end
    writebacks++;
  endtask

  initial begin : bus_slave
    bus_r     = '0;
    bus_ready = '0;
    for (int i = 0; i < 4096; i++) begin
      slave_mem[i] = fill_byte(12'(i));
    end
    forever begin
      @(negedge clk);
      if (bus_aw.valid) begin
        serve_write();
      end else if (bus_ar.valid) begin
        serve_read();
      end
    end
  end

  // ==============================
  // response checker
  // ==============================
  initial begin : compare_responses
    req_rec_t    e;
    logic        exp_ale;
    logic [31:0] exp_data;
    forever begin
      @(negedge clk);
      if (rsp.valid) begin
        assert (pending_q.size() != 0) else begin
          $display("response at %0t with no request outstanding", $time);
          stop_with_failure();
        end
        e = pending_q.pop_front();
        exp_ale = is_misaligned(e.align, e.addr);
        assert (rsp.ale == exp_ale) else begin
          $display("FAIL %0t: ale %0b at 0x%03h align %0d, expected %0b", $time,
                   rsp.ale, e.addr, e.align, exp_ale);
          stop_with_failure();
        end
        exp_data = '0;
        if (!exp_ale && e.op == MEM_LOAD) begin
          exp_data = expected_load(e.addr, e.align);
        end else if (!exp_ale) begin
          apply_store(e.addr, e.align, e.wdata);
        end
        // an aligned store returns no load data
        if (exp_ale || e.op == MEM_LOAD) begin
          assert (rsp.rdata == exp_data) else begin
            $display("FAIL %0t: load 0x%03h align %0d returned %08h, expected %08h", $time,
                     e.addr, e.align, rsp.rdata, exp_data);
            stop_with_failure();
          end
        end
        if (e.chk_lat) begin
          // driven half a cycle before acceptance, sampled mid-cycle two later
          assert ($time - e.t_issue == 64'd200) else begin
            $display("FAIL %0t: hit response after %0d cycles, expected 2 cycles", $time,
                     ($time - e.t_issue) / 64'd100);
            stop_with_failure();
          end
        end
      end
    end
  end

  // ==============================
  // stimulus
  // ==============================
  task automatic send_request(mem_op_e op, align_e al, logic [11:0] addr,
                              logic [31:0] wdata, logic chk_lat);
    req_rec_t rec;
    int       waited;
    req.valid  = 1'b1;
    req.mem_op = op;
    req.align  = al;
    req.vaddr  = {20'h0, addr};
    req.wdata  = wdata;
    waited = 0;
    while (!req_ready) begin
      @(negedge clk);
      waited++;
      assert (waited < 1000) else begin
        $display("request to 0x%03h was never accepted", addr);
        stop_with_failure();
      end
    end
    rec.op      = op;
    rec.align   = al;
    rec.addr    = addr;
    rec.wdata   = wdata;
    rec.chk_lat = chk_lat;
    rec.t_issue = $time;
    pending_q.push_back(rec);
    @(negedge clk);
    req.valid = 1'b0;
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    while (pending_q.size() != 0) begin
      @(negedge clk);
      waited++;
      assert (waited < 2000) else begin
        $display("responses still missing after %0d cycles", waited);
        stop_with_failure();
      end
    end
  endtask

  initial begin : main
    logic [11:0] a;
    mem_op_e     op;
    align_e      al;
    int          seen;
    int          waited;
    void'($urandom(32'hd97c5e05));
    req = '0;
    for (int i = 0; i < 4096; i++) begin
      ref_mem[i] = fill_byte(12'(i));
    end
    waited = 0;
    while (!rst_n) begin
      @(negedge clk);
      waited++;
      assert (waited < 20) else begin
        $display("reset was never released");
        stop_with_failure();
      end
    end
    assert (req_ready && !rsp.valid && !bus_ar.valid && !bus_aw.valid && !bus_w.valid)
    else begin
      $display("outputs not at their idle values after reset");
      stop_with_failure();
    end

    // miss after reset, then a timed hit on the same line
    seen = reads;
    send_request(MEM_LOAD, ALIGN_W, 12'h100, '0, 1'b0);
    drain_responses();
    assert (reads == seen + 1) else begin
      $display("first load after reset did not refill its line");
      stop_with_failure();
    end
    send_request(MEM_LOAD, ALIGN_W, 12'h104, '0, 1'b1);
    drain_responses();
    assert (reads == seen + 1) else begin
      $display("second load to a cached line went to the bus");
      stop_with_failure();
    end

    // store miss, sub-word loads at every offset, then store hits
    send_request(MEM_STORE, ALIGN_W, 12'h204, 32'h8f7e80ff, 1'b0);
    for (int k = 0; k < 4; k++) begin
      send_request(MEM_LOAD, ALIGN_B, 12'h204 + 12'(k), '0, 1'b0);
      send_request(MEM_LOAD, ALIGN_BU, 12'h204 + 12'(k), '0, 1'b0);
    end
    for (int k = 0; k < 4; k += 2) begin
      send_request(MEM_LOAD, ALIGN_H, 12'h204 + 12'(k), '0, 1'b0);
      send_request(MEM_LOAD, ALIGN_HU, 12'h204 + 12'(k), '0, 1'b0);
    end
    send_request(MEM_LOAD, ALIGN_W, 12'h200, '0, 1'b0);
    send_request(MEM_STORE, ALIGN_B, 12'h209, 32'h000000a5, 1'b0);
    send_request(MEM_STORE, ALIGN_H, 12'h20a, 32'h00008001, 1'b0);
    send_request(MEM_STORE, ALIGN_BU, 12'h203, 32'h00000080, 1'b0);
    send_request(MEM_LOAD, ALIGN_W, 12'h208, '0, 1'b0);
    send_request(MEM_LOAD, ALIGN_B, 12'h209, '0, 1'b0);
    send_request(MEM_LOAD, ALIGN_H, 12'h20a, '0, 1'b0);
    send_request(MEM_LOAD, ALIGN_W, 12'h200, '0, 1'b0);
    drain_responses();

    // three lines in set 5 force out a dirty line
    seen = writebacks;
    send_request(MEM_STORE, ALIGN_W, 12'h350, 32'hdeadbeef, 1'b0);
    send_request(MEM_STORE, ALIGN_H, 12'h756, 32'h1234c0de, 1'b0);
    send_request(MEM_LOAD, ALIGN_W, 12'hb58, '0, 1'b0);
    drain_responses();
    assert (writebacks > seen) else begin
      $display("no write-back after three lines were placed in one set");
      stop_with_failure();
    end
    send_request(MEM_LOAD, ALIGN_W, 12'h350, '0, 1'b0);
    send_request(MEM_LOAD, ALIGN_H, 12'h756, '0, 1'b0);
    send_request(MEM_LOAD, ALIGN_W, 12'hb58, '0, 1'b0);
    drain_responses();

    // misaligned requests stay off the bus
    seen = reads + writebacks;
    send_request(MEM_LOAD, ALIGN_H, 12'h401, '0, 1'b0);
    send_request(MEM_LOAD, ALIGN_W, 12'h402, '0, 1'b0);
    send_request(MEM_LOAD, ALIGN_HU, 12'h403, '0, 1'b0);
    send_request(MEM_STORE, ALIGN_W, 12'h405, 32'h11223344, 1'b0);
    send_request(MEM_STORE, ALIGN_H, 12'h407, 32'h00005566, 1'b0);
    drain_responses();
    assert (reads + writebacks == seen) else begin
      $display("a misaligned request caused bus traffic");
      stop_with_failure();
    end

    // random mixed traffic, half of it in the low 1 KB for more hits
    for (int n = 0; n < 2000; n++) begin
      op = ($urandom_range(0, 2) == 0) ? MEM_STORE : MEM_LOAD;
      al = align_e'($urandom_range(0, 4));
      a  = ($urandom_range(0, 1) == 1) ? 12'($urandom & 32'h3ff) : 12'($urandom);
      if ($urandom_range(0, 15) != 0) begin
        case (al)
          ALIGN_H, ALIGN_HU: a[0] = 1'b0;
          ALIGN_W:           a[1:0] = 2'b00;
          default:           ;
        endcase
      end
      send_request(op, al, a, $urandom, 1'b0);
      if ($urandom_range(0, 7) == 0) begin
        @(negedge clk);
      end
    end
    drain_responses();

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
dcache_pkg.sv
dcache_ram.sv
dcache_lookup.sv
dcache_access.sv
dcache_miss_fsm.sv
dcache_top.sv
tb_clk_gen.sv
dcache_sva.sv
dcache_tb.sv

/* run.sh */
#!/bin/sh
# build the cache testbench with Verilator, run it, and search the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb \
  -f sources.f -o dcache_sim \
  && ./obj_dir/dcache_sim > sim.log 2>&1
grep -q "^TEST OK$" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
